// File: Bender.yml
package:
  name: dmac_fifo

sources:
  - verilog/dmacFifoPkg.sv
  - verilog/fifoLaneIf.sv
  - verilog/laneStrobeDecoder.sv
  - verilog/laneSequencer.sv
  - verilog/hostBusSlave.sv
  - verilog/occupancyCounter.sv
  - verilog/fifoBuffer.sv
  - verilog/dmacFifo.sv
  - target: test
    files:
      - tests/tbClockGen.sv
      - tests/fifoChecker.sv
      - tests/dmacFifoTb.sv

// File: src.f
verilog/dmacFifoPkg.sv
verilog/fifoLaneIf.sv
verilog/laneStrobeDecoder.sv
verilog/laneSequencer.sv
verilog/hostBusSlave.sv
verilog/occupancyCounter.sv
verilog/fifoBuffer.sv
verilog/dmacFifo.sv
tests/tbClockGen.sv
tests/fifoChecker.sv
tests/dmacFifoTb.sv

// File: tests/dmacFifoTb.sv
// Top of the DMA FIFO testbench, applies the stimulus table to the DUT and reports the result
`timescale 1ns/100ps
`default_nettype none

module dmacFifoTb;

    localparam int FIFO_DEPTH   = 8;
    localparam int CLK_PERIOD   = 4;    // ns
    localparam int RESET_CYCLES = 8;
    localparam int ROW_CYCLES   = 10;   // Watchdog budget per row

    // Row operations
    localparam int OP_HOST_WR = 0;
    localparam int OP_HOST_RD = 1;
    localparam int OP_ACR_WR  = 2;
    localparam int OP_ACR_RD  = 3;
    localparam int OP_PUSH    = 4;
    localparam int OP_PULL    = 5;
    localparam int OP_IDLE    = 6;

    logic                  ACR_WR;
    logic                  RST_FIFO_;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    logic [1:0]            wbAdr;
    logic [3:0]            wbSel;
    dmacFifoPkg::longWordT wbWrData;
    dmacFifoPkg::longWordT wbRdData;
    logic                  wbAck;
    logic                  scsiValid;
    logic                  scsiReady;
    dmacFifoPkg::byteT     scsiWrByte;
    dmacFifoPkg::byteT     scsiRdByte;
    logic                  fifoFull;
    logic                  fifoEmpty;
    dmacFifoPkg::bytePtrT  bytePtr;

    // Stimulus table, one column per queue
    int                    opTab[$];
    logic [1:0]            adrTab[$];
    logic [3:0]            selTab[$];
    dmacFifoPkg::longWordT dataTab[$];
    logic                  fullTab[$];
    logic                  emptyTab[$];
    dmacFifoPkg::bytePtrT  ptrTab[$];
    logic                  tableReady = 1'b0;
    integer                seed = 32'h9969;
    dmacFifoPkg::longWordT randWord;

    tbClockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_tbClockGen (
        .clk  (ACR_WR),
        .rstN (RST_FIFO_)
    );

    dmacFifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_dmacFifo (
        .ACR_WR, .RST_FIFO_,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbSel, .wbWrData, .wbRdData, .wbAck,
        .scsiValid, .scsiReady, .scsiWrByte, .scsiRdByte,
        .fifoFull, .fifoEmpty, .bytePtr
    );

    fifoChecker #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifoChecker (
        .ACR_WR, .RST_FIFO_,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbSel, .wbWrData, .wbRdData, .wbAck,
        .scsiValid, .scsiReady, .scsiWrByte, .scsiRdByte,
        .fifoFull, .fifoEmpty, .bytePtr
    );

    function automatic string opName(input int op);
        case (op)
            OP_HOST_WR: return "host write";
            OP_HOST_RD: return "host read";
            OP_ACR_WR:  return "ACR write";
            OP_ACR_RD:  return "ACR read";
            OP_PUSH:    return "SCSI push";
            OP_PULL:    return "SCSI pull";
            default:    return "idle";
        endcase
    endfunction

    task automatic addRow(input int op, input logic [1:0] adr, input logic [3:0] sel,
                          input dmacFifoPkg::longWordT data, input logic expFull,
                          input logic expEmpty, input dmacFifoPkg::bytePtrT expPtr);
        opTab.push_back(op);
        adrTab.push_back(adr);
        selTab.push_back(sel);
        dataTab.push_back(data);
        fullTab.push_back(expFull);
        emptyTab.push_back(expEmpty);
        ptrTab.push_back(expPtr);
    endtask

    // Expected flags and pointer follow the occupancy and byte pointer rules
    task automatic buildTable();
        int k;
        addRow(OP_ACR_RD,  2'd3, 4'hF, '0, 1'b0, 1'b1, 2'd0);   // Reset state
        addRow(OP_PUSH,    2'd0, 4'h0, '0, 1'b0, 1'b1, 2'd0);   // Not ready, ignored
        addRow(OP_HOST_RD, 2'd0, 4'hF, '0, 1'b0, 1'b1, 2'd0);
        for (k = 1; k <= 8; k++) begin
            addRow(OP_HOST_WR, 2'd0, 4'hF, 32'h00112233 + 32'h11111111 * k,
                   k == 8, 1'b0, 2'd0);
        end
        addRow(OP_HOST_WR, 2'd0, 4'hF, 32'hDEADBEEF, 1'b1, 1'b0, 2'd0);  // Full, refused
        addRow(OP_HOST_RD, 2'd0, 4'hF, '0, 1'b1, 1'b0, 2'd0);           // Wrong direction
        for (k = 1; k <= 32; k++) begin
            addRow(OP_PULL, 2'd0, 4'h0, '0, k < 4, k == 32, k % 4);
        end
        addRow(OP_PUSH,    2'd0, 4'h0, '0, 1'b0, 1'b1, 2'd0);
        // Half-word pair makes one entry, odd sel is dropped
        addRow(OP_HOST_WR, 2'd0, 4'b1100, 32'hCAFEF00D, 1'b0, 1'b1, 2'd0);
        addRow(OP_HOST_WR, 2'd0, 4'b0011, 32'h12345678, 1'b0, 1'b0, 2'd0);
        addRow(OP_HOST_WR, 2'd0, 4'b0110, 32'hFFFFFFFF, 1'b0, 1'b0, 2'd0);
        for (k = 1; k <= 4; k++) begin
            addRow(OP_PULL, 2'd0, 4'h0, '0, 1'b0, k == 4, k % 4);
        end
        // SCSI to memory, odd word start
        addRow(OP_ACR_WR,  2'd3, 4'hF, 32'h3, 1'b0, 1'b1, 2'd2);
        addRow(OP_ACR_RD,  2'd3, 4'hF, '0, 1'b0, 1'b1, 2'd2);
        addRow(OP_HOST_RD, 2'd0, 4'hF, '0, 1'b0, 1'b1, 2'd2);   // Empty, returns zero
        addRow(OP_PUSH,    2'd0, 4'h0, '0, 1'b0, 1'b1, 2'd3);
        addRow(OP_PUSH,    2'd0, 4'h0, '0, 1'b0, 1'b0, 2'd0);   // Lane 3 commits
        for (k = 1; k <= 8; k++) begin
            addRow(OP_PUSH, 2'd0, 4'h0, '0, 1'b0, 1'b0, k % 4);
        end
        for (k = 1; k <= 3; k++) begin
            addRow(OP_HOST_RD, 2'd0, 4'hF, '0, 1'b0, k == 3, 2'd0);
        end
        addRow(OP_HOST_RD, 2'd0, 4'hF, '0, 1'b0, 1'b1, 2'd0);
        addRow(OP_ACR_WR,  2'd3, 4'hF, 32'h0, 1'b0, 1'b1, 2'd0);
        addRow(OP_ACR_RD,  2'd3, 4'hF, '0, 1'b0, 1'b1, 2'd0);
        addRow(OP_IDLE,    2'd0, 4'h0, '0, 1'b0, 1'b1, 2'd0);
    endtask

    // One Wishbone classic access, called on a falling edge
    task automatic driveHost(input logic we, input logic [1:0] adr, input logic [3:0] sel,
                             input dmacFifoPkg::longWordT data);
        wbCyc    = 1'b1;
        wbStb    = 1'b1;
        wbWe     = we;
        wbAdr    = adr;
        wbSel    = sel;
        wbWrData = data;
        @(negedge ACR_WR);
        while (!wbAck) begin
            @(negedge ACR_WR);            // Watchdog covers a missing ack
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge ACR_WR);                // Ack has dropped here
    endtask

    // Valid for one edge, transfer only if ready
    task automatic driveByte(input dmacFifoPkg::byteT b);
        scsiValid  = 1'b1;
        scsiWrByte = b;
        @(negedge ACR_WR);
        scsiValid  = 1'b0;
    endtask

    task automatic applyRow(input int r);
        case (opTab[r])
            OP_HOST_WR, OP_ACR_WR: driveHost(1'b1, adrTab[r], selTab[r], dataTab[r]);
            OP_HOST_RD, OP_ACR_RD: driveHost(1'b0, adrTab[r], selTab[r], '0);
            OP_PUSH, OP_PULL: begin
                randWord = $random(seed);
                driveByte(randWord[7:0]);
            end
            default: @(negedge ACR_WR);
        endcase
    endtask

    initial begin
        wbCyc      = 1'b0;
        wbStb      = 1'b0;
        wbWe       = 1'b0;
        wbAdr      = '0;
        wbSel      = '0;
        wbWrData   = '0;
        scsiValid  = 1'b0;
        scsiWrByte = '0;
        buildTable();
        tableReady = 1'b1;
        wait (RST_FIFO_ === 1'b1);
        @(negedge ACR_WR);
        for (int r = 0; r < opTab.size(); r++) begin
            applyRow(r);
            i_fifoChecker.checkRow(r, opName(opTab[r]), fullTab[r], emptyTab[r], ptrTab[r]);
        end
        $display("Summary: %0d rows, %0d passed, %0d failed, %0d errors", opTab.size(),
                 i_fifoChecker.passedRows, i_fifoChecker.failedRows, i_fifoChecker.errorCount);
        if (i_fifoChecker.errorCount == 0 && i_fifoChecker.failedRows == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog, sized from the table length
    initial begin
        wait (tableReady);
        #((RESET_CYCLES + opTab.size() * ROW_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the time allowed for %0d rows",
                 opTab.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/fifoChecker.sv
// Reference model and scoreboard that watches the DMA FIFO ports every clock for the testbench top
`timescale 1ns/100ps
`default_nettype none

module fifoChecker #(
    parameter int FIFO_DEPTH = 8
) (
    input logic                  ACR_WR,
    input logic                  RST_FIFO_,
    input logic                  wbCyc,
    input logic                  wbStb,
    input logic                  wbWe,
    input logic [1:0]            wbAdr,
    input logic [3:0]            wbSel,
    input dmacFifoPkg::longWordT wbWrData,
    input dmacFifoPkg::longWordT wbRdData,
    input logic                  wbAck,
    input logic                  scsiValid,
    input logic                  scsiReady,
    input dmacFifoPkg::byteT     scsiWrByte,
    input dmacFifoPkg::byteT     scsiRdByte,
    input logic                  fifoFull,
    input logic                  fifoEmpty,
    input dmacFifoPkg::bytePtrT  bytePtr
);

    dmacFifoPkg::longWordT refQ[$];            // Committed entries with the head first
    dmacFifoPkg::longWordT pending = '0;       // Entry being assembled from zero lanes
    dmacFifoPkg::acrT      refAcr = '0;
    dmacFifoPkg::bytePtrT  refPtr = '0;
    logic                  ackDue = 1'b0;      // Ack expected at the next edge
    logic                  readDue = 1'b0;
    dmacFifoPkg::longWordT expRead = '0;
    int                    errorCount = 0;
    int                    passedRows = 0;
    int                    failedRows = 0;
    int                    rowErrBase = 0;     // Error count when the row started

    // Ready means room to fill toward memory or data to drain toward SCSI
    function automatic logic refReady();
        if (refAcr[dmacFifoPkg::ACR_DIR_BIT]) begin
            return refQ.size() < FIFO_DEPTH;
        end
        return refQ.size() > 0;
    endfunction

    // Lane 0 is the most significant byte
    function automatic int laneShift(dmacFifoPkg::bytePtrT l);
        return 8 * (3 - int'(l));
    endfunction

    task automatic reportMismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, sig, got, exp);
        errorCount++;
    endtask

    task automatic reportFault(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errorCount++;
    endtask

    // Bus access as the host slave should perform it
    task automatic hostStep();
        logic dirToMem;
        dirToMem = refAcr[dmacFifoPkg::ACR_DIR_BIT];
        ackDue   = 1'b1;
        if (wbWe) begin
            if (wbAdr == 2'd3) begin
                refAcr = wbWrData[1:0];
                refPtr = wbWrData[dmacFifoPkg::ACR_ODD_BIT] ? 2'd2 : 2'd0;
            end else if (wbAdr == 2'd0 && !dirToMem && refQ.size() < FIFO_DEPTH) begin
                case (wbSel)
                    4'b1111: begin
                        refQ.push_back(wbWrData);
                        pending = '0;
                    end
                    4'b1100: pending[31:16] = wbWrData[31:16];   // No commit yet
                    4'b0011: begin
                        pending[15:0] = wbWrData[15:0];
                        refQ.push_back(pending);
                        pending = '0;
                    end
                    default: ;                                    // Acked and ignored
                endcase
            end
        end else begin
            readDue = 1'b1;
            if (wbAdr == 2'd3) begin
                expRead = {30'd0, refAcr};
            end else if (wbAdr == 2'd0 && dirToMem && refQ.size() > 0) begin
                expRead = refQ.pop_front();
            end else begin
                expRead = '0;                                     // Refused or unused
            end
        end
    endtask

    // One SCSI byte at the model pointer
    task automatic scsiStep();
        int sh;
        sh = laneShift(refPtr);
        if (refAcr[dmacFifoPkg::ACR_DIR_BIT]) begin
            pending[sh +: 8] = scsiWrByte;
            if (refPtr == 2'd3) begin
                refQ.push_back(pending);
                pending = '0;
            end
        end else begin
            if (scsiRdByte !== refQ[0][sh +: 8]) begin
                reportMismatch("scsiRdByte", scsiRdByte, refQ[0][sh +: 8]);
            end
            if (refPtr == 2'd3) begin
                void'(refQ.pop_front());
            end
        end
        refPtr = refPtr + 2'd1;
    endtask

    // Samples pre-edge values of inputs driven on the falling edge
    always @(posedge ACR_WR) begin
        if (!RST_FIFO_) begin
            refQ.delete();
            pending = '0;
            refAcr  = '0;
            refPtr  = '0;
            ackDue  = 1'b0;
            readDue = 1'b0;
        end else begin
            if (ackDue && !wbAck) begin
                reportFault("host access was not acknowledged in the following cycle");
            end
            if (readDue && wbRdData !== expRead) begin
                reportMismatch("wbRdData", wbRdData, expRead);
            end
            ackDue  = 1'b0;
            readDue = 1'b0;
            if (wbCyc && wbStb && !wbAck) begin
                hostStep();
            end
            if (scsiValid && refReady()) begin
                scsiStep();                   // Valid ignored while not ready
            end
        end
    end

    // Checks flags and pointer after a row and prints its result line
    task automatic checkRow(input int row, input string opName, input logic expFull,
                            input logic expEmpty, input dmacFifoPkg::bytePtrT expPtr);
        if (fifoFull !== expFull) begin
            reportMismatch("fifoFull", fifoFull, expFull);
        end
        if (fifoEmpty !== expEmpty) begin
            reportMismatch("fifoEmpty", fifoEmpty, expEmpty);
        end
        if (bytePtr !== expPtr) begin
            reportMismatch("bytePtr", bytePtr, expPtr);
        end
        if (scsiReady !== refReady()) begin
            reportMismatch("scsiReady", scsiReady, refReady());
        end
        if (errorCount == rowErrBase) begin
            passedRows++;
            $display("row %0d %s ok", row, opName);
        end else begin
            failedRows++;
            $display("row %0d %s failed with %0d errors", row, opName, errorCount - rowErrBase);
        end
        rowErrBase = errorCount;
    endtask

endmodule

`default_nettype wire

// File: tests/tbClockGen.sv
// Clock and reset source of the DMA FIFO testbench, instantiated once by the testbench top
`timescale 1ns/100ps
`default_nettype none

module tbClockGen #(
    parameter int PERIOD       = 4,   // ns
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a falling edge, away from the DUT's sampling edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/dmacFifo.sv
// Top of the SCSI DMA data FIFO, joins host slave, lane sequencer, buffer and counter
`timescale 1ns/100ps
`default_nettype none

module dmacFifo #(
    parameter int FIFO_DEPTH = 8    // Entries of 32 bits
) (
    input  logic                  ACR_WR,
    input  logic                  RST_FIFO_,
    // Wishbone classic slave
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  logic [1:0]            wbAdr,
    input  logic [3:0]            wbSel,
    input  dmacFifoPkg::longWordT wbWrData,
    output dmacFifoPkg::longWordT wbRdData,
    output logic                  wbAck,
    // SCSI byte port
    input  logic                  scsiValid,
    output logic                  scsiReady,
    input  dmacFifoPkg::byteT     scsiWrByte,
    output dmacFifoPkg::byteT     scsiRdByte,
    // Status
    output logic                  fifoFull,
    output logic                  fifoEmpty,
    output dmacFifoPkg::bytePtrT  bytePtr
);

    logic                  loadHigh;  // Host high half load
    logic                  loadLow;   // Host low half load, commits
    logic                  hostPop;   // Accepted host data read
    dmacFifoPkg::longWordT hostData;
    dmacFifoPkg::acrT      acr;
    logic                  acrWrite;

    fifoLaneIf laneBus ();

    hostBusSlave i_hostBusSlave (
        .ACR_WR, .RST_FIFO_,
        .wbCyc, .wbStb, .wbWe, .wbAdr, .wbSel, .wbWrData, .wbRdData, .wbAck,
        .full     (fifoFull),
        .empty    (fifoEmpty),
        .head     (laneBus.rdData),  // Read data comes straight off the head entry
        .loadHigh, .loadLow, .hostPop, .hostData, .acr, .acrWrite
    );

    laneSequencer i_laneSequencer (
        .ACR_WR, .RST_FIFO_,
        .loadHigh, .loadLow, .hostPop, .hostData, .acr, .acrWrite,
        .full     (fifoFull),
        .empty    (fifoEmpty),
        .scsiValid, .scsiReady, .scsiWrByte, .scsiRdByte,
        .bytePtr,
        .lane     (laneBus.sequencer)
    );

    fifoBuffer #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifoBuffer (
        .ACR_WR, .RST_FIFO_,
        .lane (laneBus.storage)
    );

    occupancyCounter #(.FIFO_DEPTH(FIFO_DEPTH)) i_occupancyCounter (
        .ACR_WR, .RST_FIFO_,
        .mon   (laneBus.monitor),
        .full  (fifoFull),
        .empty (fifoEmpty)
    );

endmodule

`default_nettype wire

// File: verilog/dmacFifoPkg.sv
// Shared vector types and ACR bit positions for the SCSI DMA data FIFO, used by scoped name
`default_nettype none

package dmacFifoPkg;

    // Host data word and one FIFO entry
    typedef logic [31:0] longWordT;

    // Single SCSI byte
    typedef logic [7:0] byteT;

    // Lane write enables, bit 3 is lane 0 (31:24), bit 0 is lane 3 (7:0)
    typedef logic [3:0] laneMaskT;

    // Byte pointer, names the lane of the next SCSI byte
    typedef logic [1:0] bytePtrT;

    // ACR contents
    typedef logic [1:0] acrT;

    localparam int ACR_DIR_BIT = 0; // 1 = SCSI to memory
    localparam int ACR_ODD_BIT = 1; // Start at odd word, pointer loads 2

endpackage

`default_nettype wire

// File: verilog/fifoBuffer.sv
// Entry storage of the DMA FIFO, lane writes at next-in and clearing pops at next-out
`timescale 1ns/100ps
`default_nettype none

module fifoBuffer #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        ACR_WR,
    input  logic        RST_FIFO_,
    fifoLaneIf.storage  lane
);

    localparam int             PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_ENTRY = PTR_W'(FIFO_DEPTH - 1);

    dmacFifoPkg::longWordT mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      nextIn;    // Entry being built
    logic [PTR_W-1:0]      nextOut;   // Head entry

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                mem[i] <= '0;       // Partial entries rely on zero lanes
            end
            nextIn  <= '0;
            nextOut <= '0;
        end else begin
            if (lane.pop) begin
                mem[nextOut] <= '0;
                nextOut      <= (nextOut == LAST_ENTRY) ? '0 : nextOut + 1'b1;
            end
            for (int l = 0; l < 4; l++) begin
                if (lane.laneWe[l]) begin
                    mem[nextIn][8*l +: 8] <= lane.wrData[8*l +: 8];
                end
            end
            if (lane.commit) begin
                nextIn <= (nextIn == LAST_ENTRY) ? '0 : nextIn + 1'b1;
            end
        end
    end

    // Asynchronous head read
    assign lane.rdData = mem[nextOut];

endmodule

`default_nettype wire

// File: verilog/fifoLaneIf.sv
// Lane write, commit, pop and head data bundle between sequencer, buffer and counter
`timescale 1ns/100ps
`default_nettype none

interface fifoLaneIf;

    dmacFifoPkg::laneMaskT laneWe;  // Per-lane write enables for the next-in entry
    dmacFifoPkg::longWordT wrData;  // Write data, lanes already steered
    logic                  commit;  // Advance next-in with this write
    logic                  pop;     // Advance next-out, clear departing entry
    dmacFifoPkg::longWordT rdData;  // Head entry, always valid

    // Lane sequencer side
    modport sequencer (output laneWe, output wrData, output commit, output pop,
                       input rdData);

    // Entry storage
    modport storage (input laneWe, input wrData, input commit, input pop,
                     output rdData);

    // Occupancy tracking only needs the pointer moves
    modport monitor (input commit, input pop);

endinterface

`default_nettype wire

// File: verilog/hostBusSlave.sv
// Wishbone classic slave that holds the ACR and turns bus cycles into loads and pops for the FIFO top
`timescale 1ns/100ps
`default_nettype none

module hostBusSlave (
    input  logic                  ACR_WR,
    input  logic                  RST_FIFO_,
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  logic [1:0]            wbAdr,
    input  logic [3:0]            wbSel,
    input  dmacFifoPkg::longWordT wbWrData,
    output dmacFifoPkg::longWordT wbRdData,
    output logic                  wbAck,
    input  logic                  full,
    input  logic                  empty,
    input  dmacFifoPkg::longWordT head,     // Current head entry
    output logic                  loadHigh, // Lanes 0 and 1 without commit
    output logic                  loadLow,  // Lanes 2 and 3 with commit
    output logic                  hostPop,
    output dmacFifoPkg::longWordT hostData,
    output dmacFifoPkg::acrT      acr,
    output logic                  acrWrite
);

    localparam logic [1:0] DATA_ADR = 2'd0;
    localparam logic [1:0] ACR_ADR  = 2'd3;

    logic             access;   // First edge of a cycle before ack
    logic             dataWr;
    logic             dataRd;
    logic             wrOk;     // Data write passes direction and full tests
    logic             dirToMem;
    dmacFifoPkg::acrT acrReg;

    assign access   = wbCyc && wbStb && !wbAck;
    assign dataWr   = access && wbWe && (wbAdr == DATA_ADR);
    assign dataRd   = access && !wbWe && (wbAdr == DATA_ADR);
    assign dirToMem = acrReg[dmacFifoPkg::ACR_DIR_BIT];

    // Host may only fill when draining toward SCSI
    assign wrOk     = dataWr && !dirToMem && !full;
    assign loadHigh = wrOk && (wbSel == 4'b1111 || wbSel == 4'b1100);
    assign loadLow  = wrOk && (wbSel == 4'b1111 || wbSel == 4'b0011); // 1111 and 0011 commit

    // Reads only pop in the SCSI to memory direction
    assign hostPop  = dataRd && dirToMem && !empty;

    assign acrWrite = access && wbWe && (wbAdr == ACR_ADR);
    assign hostData = wbWrData;   // Also carries the new ACR value to the sequencer
    assign acr      = acrReg;

    // Single-cycle ack and ACR
    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            wbAck  <= 1'b0;
            acrReg <= '0;
        end else begin
            wbAck <= access;                    // Refused accesses are acked too
            if (acrWrite) begin
                acrReg <= wbWrData[1:0];
            end
        end
    end

    // Read data captured at the access edge before the pop moves the head
    always_ff @(posedge ACR_WR) begin
        if (access) begin
            if (hostPop) begin
                wbRdData <= head;
            end else if (!wbWe && wbAdr == ACR_ADR) begin
                wbRdData <= dmacFifoPkg::longWordT'(acrReg); // Zero-extended
            end else begin
                wbRdData <= '0;                 // Refused read or unused address
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/laneSequencer.sv
// Byte pointer and SCSI handshake of the DMA FIFO, steers lane data and makes commit and pop
`timescale 1ns/100ps
`default_nettype none

module laneSequencer (
    input  logic                  ACR_WR,
    input  logic                  RST_FIFO_,
    input  logic                  loadHigh,
    input  logic                  loadLow,
    input  logic                  hostPop,
    input  dmacFifoPkg::longWordT hostData,
    input  dmacFifoPkg::acrT      acr,
    input  logic                  acrWrite,
    input  logic                  full,
    input  logic                  empty,
    input  logic                  scsiValid,
    output logic                  scsiReady,
    input  dmacFifoPkg::byteT     scsiWrByte,
    output dmacFifoPkg::byteT     scsiRdByte,
    output dmacFifoPkg::bytePtrT  bytePtr,
    fifoLaneIf.sequencer          lane
);

    logic dirToMem;
    logic scsiXfer;   // Valid and ready at this edge
    logic scsiPush;   // SCSI to memory byte
    logic scsiPull;   // Memory to SCSI byte
    logic lastLane;

    assign dirToMem  = acr[dmacFifoPkg::ACR_DIR_BIT];
    assign scsiReady = dirToMem ? !full : !empty;   // Flags are registered already
    assign scsiXfer  = scsiValid && scsiReady;
    assign scsiPush  = scsiXfer && dirToMem;
    assign scsiPull  = scsiXfer && !dirToMem;
    assign lastLane  = (bytePtr == 2'd3);

    laneStrobeDecoder i_laneStrobeDecoder (
        .loadHigh,
        .loadLow,
        .loadByte (scsiPush),
        .bytePtr,
        .laneWe   (lane.laneWe)
    );

    // SCSI byte goes onto every lane, the strobes pick one
    assign lane.wrData = scsiPush ? {4{scsiWrByte}} : hostData;
    assign lane.commit = loadLow || (scsiPush && lastLane);
    assign lane.pop    = hostPop || (scsiPull && lastLane);

    // Lane 0 sits in bits 31:24, so lane n starts at 8*(3-n)
    assign scsiRdByte  = lane.rdData[{~bytePtr, 3'b000} +: 8];

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            bytePtr <= '0;
        end else if (acrWrite) begin
            // New ACR value decides the starting lane
            bytePtr <= hostData[dmacFifoPkg::ACR_ODD_BIT] ? 2'd2 : 2'd0;
        end else if (scsiXfer) begin
            bytePtr <= bytePtr + 2'd1;  // Wraps after lane 3
        end
    end

endmodule

`default_nettype wire

// File: verilog/laneStrobeDecoder.sv
// Lane write strobe decode of the DMA FIFO, from word or byte loads and the byte pointer
`timescale 1ns/100ps
`default_nettype none

module laneStrobeDecoder (
    input  logic                   loadHigh,  // Lanes 0 and 1
    input  logic                   loadLow,   // Lanes 2 and 3
    input  logic                   loadByte,  // One lane at the byte pointer
    input  dmacFifoPkg::bytePtrT   bytePtr,
    output dmacFifoPkg::laneMaskT  laneWe
);

    dmacFifoPkg::laneMaskT byteMask;

    // Lane n maps to mask bit 3-n
    assign byteMask = loadByte ? dmacFifoPkg::laneMaskT'(4'b1000 >> bytePtr) : '0;

    assign laneWe = {{2{loadHigh}}, {2{loadLow}}} | byteMask;

    // Host word loads and SCSI byte loads belong to opposite directions
    byteWordExclusive: assert final (!(loadByte && (loadHigh || loadLow)));

endmodule

`default_nettype wire

// File: verilog/occupancyCounter.sv
// Entry counter of the DMA FIFO, registers full and empty from the commit and pop stream
`timescale 1ns/100ps
`default_nettype none

module occupancyCounter #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       ACR_WR,
    input  logic       RST_FIFO_,
    fifoLaneIf.monitor mon,
    output logic       full,
    output logic       empty
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);   // Holds 0 to FIFO_DEPTH

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] countNext;

    always_comb begin
        countNext = count;
        if (mon.commit && !mon.pop) begin
            countNext = count + 1'b1;
        end else if (mon.pop && !mon.commit) begin
            countNext = count - 1'b1;
        end                                 // Both at once leaves count alone
    end

    always_ff @(posedge ACR_WR or negedge RST_FIFO_) begin
        if (!RST_FIFO_) begin
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            count <= countNext;
            full  <= (countNext == CNT_W'(FIFO_DEPTH));
            empty <= (countNext == '0);
        end
    end

    // Sequencer and host slave must respect the flags
    noCommitWhenFull: assert property (
        @(posedge ACR_WR) disable iff (!RST_FIFO_) mon.commit |-> !full
    );
    noPopWhenEmpty: assert property (
        @(posedge ACR_WR) disable iff (!RST_FIFO_) mon.pop |-> !empty
    );

endmodule

`default_nettype wire
